// ==== filelist.f ====
alu_pkg.sv
cpu_regfile.sv
cpu_alu.sv
cpu_exec_seq.sv
cpu_exec_unit.sv
tb_cpu_exec_sva.sv
tb_cpu_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the execute-stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_exec \
    -f filelist.f -o tb_cpu_exec > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_cpu_exec > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log && { echo "PASS"; exit 0; }
echo "no result found in sim.log"
exit 1

// ==== tb_cpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_exec import alu_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int DONE_LIMIT  = 40;
    // wait for ready plus the longest shift
    localparam int OP_CYCLES   = DONE_LIMIT + 2;
    localparam int OPS_RESET   = 1;
    localparam int OPS_ARITH   = 15 + 2 * 20;
    localparam int OPS_COMPARE = 4 + 2 * 14;
    localparam int OPS_SHIFT   = 2 + 2 * 3 * 6;
    localparam int OPS_ZERO    = 5;
    localparam int TOTAL_OPS   = OPS_RESET + OPS_ARITH + OPS_COMPARE + OPS_SHIFT + OPS_ZERO;
    localparam int WATCHDOG_NS = (TOTAL_OPS * OP_CYCLES + 10) * CLK_PERIOD + 200;
    localparam reg_addr_t GLITCH_RD = 4'd9;

    logic      I_clk;
    logic      I_reset;
    logic      start;
    alu_op_t   op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      use_imm;
    logic      ready;
    logic      done;
    word_t     result;
    logic      lt;
    logic      ltu;
    logic      eq;

    word_t       shadow [NUM_REGS];
    logic [15:0] lfsr_state = 16'd38;
    int          errors;
    int          checks;
    int          tests;
    word_t       got_result;
    logic        got_lt;
    logic        got_ltu;
    logic        got_eq;
    int          got_cycles;
    logic        got_ok;

    cpu_exec_unit uut (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .start   (start),
        .op      (op),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .use_imm (use_imm),
        .ready   (ready),
        .done    (done),
        .result  (result),
        .lt      (lt),
        .ltu     (ltu),
        .eq      (eq)
    );

    bind cpu_exec_seq tb_cpu_exec_sva seq_checks (
        .I_clk    (I_clk),
        .I_reset  (I_reset),
        .state    (state),
        .ready    (ready),
        .done     (done),
        .alu_busy (alu_busy)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word(int nbits);
        word_t w;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic is_shift(alu_op_t o);
        return (o == ALUOP_SLL) || (o == ALUOP_SRL) || (o == ALUOP_SRA);
    endfunction

    // reference model of one operation
    function automatic word_t model_alu(alu_op_t o, word_t a, word_t b);
        case (o)
            ALUOP_SUB:  return a - b;
            ALUOP_AND:  return a & b;
            ALUOP_OR:   return a | b;
            ALUOP_XOR:  return a ^ b;
            ALUOP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALUOP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALUOP_SLL:  return a << b[4:0];
            ALUOP_SRL:  return a >> b[4:0];
            ALUOP_SRA:  return $signed(a) >>> b[4:0];
            default:    return a + b;
        endcase
    endfunction

    function automatic string op_name(alu_op_t o);
        case (o)
            ALUOP_SUB:  return "sub";
            ALUOP_AND:  return "and";
            ALUOP_OR:   return "or";
            ALUOP_XOR:  return "xor";
            ALUOP_SLT:  return "slt";
            ALUOP_SLTU: return "sltu";
            ALUOP_SLL:  return "sll";
            ALUOP_SRL:  return "srl";
            ALUOP_SRA:  return "sra";
            default:    return "add";
        endcase
    endfunction

    task automatic check_word(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0d ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    // issue one operation and optionally pulse start again while the DUT is busy
    task automatic run_op(alu_op_t o, reg_addr_t a1, reg_addr_t a2, reg_addr_t d,
                          word_t im, logic ui, int glitch_at);
        int cycles;
        while (!ready) @(negedge I_clk);
        op      = o;
        rs1     = a1;
        rs2     = a2;
        rd      = d;
        imm     = im;
        use_imm = ui;
        start   = 1'b1;
        @(negedge I_clk);
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles < DONE_LIMIT) begin
            if (cycles == glitch_at) begin
                op      = ALUOP_ADD;
                rs1     = '0;
                rd      = GLITCH_RD;
                imm     = 32'h5a5a_5a5a;
                use_imm = 1'b1;
                start   = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(negedge I_clk);
            cycles++;
        end
        start = 1'b0;
        got_ok = done;
        if (!done) begin
            errors++;
            $display("no done from the DUT within %0d cycles for %s", DONE_LIMIT, op_name(o));
        end
        got_result = result;
        got_lt     = lt;
        got_ltu    = ltu;
        got_eq     = eq;
        got_cycles = cycles;
    endtask

    task automatic exec_check(alu_op_t o, reg_addr_t a1, reg_addr_t a2, reg_addr_t d,
                              word_t im, logic ui, int glitch_at);
        word_t a;
        word_t b;
        word_t exp;
        string what;
        a    = shadow[a1];
        b    = ui ? im : shadow[a2];
        exp  = model_alu(o, a, b);
        what = $sformatf("%s r%0d <- r%0d, %h", op_name(o), d, a1, b);
        run_op(o, a1, a2, d, im, ui, glitch_at);
        if (got_ok) begin
            check_word(what, got_result, exp);
            // shifts spend one cycle per bit plus load, busy drop and exit from WAIT
            check_count(what, got_cycles, is_shift(o) ? 4 + int'(b[4:0]) : 2);
            if (!is_shift(o)) begin
                check_flag({what, " lt"}, got_lt, $signed(a) < $signed(b));
                check_flag({what, " ltu"}, got_ltu, a < b);
                check_flag({what, " eq"}, got_eq, a == b);
            end
        end
        if (d != reg_addr_t'(0)) begin
            shadow[d] = exp;
        end
    endtask

    task automatic load_reg(reg_addr_t r, word_t v);
        exec_check(ALUOP_ADD, '0, '0, r, v, 1'b1, 0);
    endtask

    // adding r0 returns the register unchanged
    task automatic read_back(reg_addr_t r);
        exec_check(ALUOP_ADD, r, '0, '0, '0, 1'b0, 0);
    endtask

    task automatic compare_pair(reg_addr_t a1, reg_addr_t a2);
        exec_check(ALUOP_SLT, a1, a2, 4'd14, '0, 1'b0, 0);
        exec_check(ALUOP_SLTU, a1, a2, 4'd15, '0, 1'b0, 0);
    endtask

    task automatic end_test(string name, int err0);
        tests++;
        $display("test %-8s %s, %0d errors", name, (errors == err0) ? "ok" : "bad",
                 errors - err0);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        repeat (3) begin
            @(negedge I_clk);
            check_flag("ready after reset", ready, 1'b1);
            check_flag("done after reset", done, 1'b0);
        end
        load_reg(4'd1, rand_word(32));
        end_test("reset", err0);
    endtask

    task automatic test_arith();
        int        err0;
        alu_op_t   o;
        reg_addr_t d;
        err0 = errors;
        for (int r = 1; r < NUM_REGS; r++) begin
            load_reg(reg_addr_t'(r), rand_word(32));
        end
        for (int i = 0; i < 20; i++) begin
            o = alu_op_t'(rand_word(3) % 5);
            d = reg_addr_t'(rand_word(4));
            exec_check(o, reg_addr_t'(rand_word(4)), reg_addr_t'(rand_word(4)), d, '0, 1'b0, 0);
            read_back(d);
        end
        end_test("arith", err0);
    endtask

    task automatic test_compare();
        int err0;
        err0 = errors;
        load_reg(4'd10, 32'h8000_0000);
        load_reg(4'd11, 32'h7fff_ffff);
        load_reg(4'd12, 32'hffff_ffff);
        load_reg(4'd13, 32'h0000_0001);
        compare_pair(4'd10, 4'd11);
        compare_pair(4'd11, 4'd10);
        compare_pair(4'd12, 4'd13);
        compare_pair(4'd13, 4'd12);
        compare_pair(4'd12, 4'd0);
        compare_pair(4'd3, 4'd3);
        for (int i = 0; i < 8; i++) begin
            compare_pair(reg_addr_t'(rand_word(4)), reg_addr_t'(rand_word(4)));
        end
        end_test("compare", err0);
    endtask

    task automatic test_shift();
        int    err0;
        word_t amt;
        err0 = errors;
        // a negative source for the SRA sign fill and a positive one
        load_reg(4'd2, rand_word(32) | 32'h8000_0000);
        load_reg(4'd3, rand_word(32) & 32'h7fff_ffff);
        for (int s = 2; s <= 3; s++) begin
            for (int k = 0; k < 3; k++) begin
                for (int c = 0; c < 6; c++) begin
                    amt = (c == 0) ? 32'd0 : (c == 1) ? 32'd1 : (c == 2) ? 32'd31 : rand_word(32);
                    exec_check(alu_op_t'(ALUOP_SLL + k), reg_addr_t'(s), '0, 4'd14, amt, 1'b1, 0);
                end
            end
        end
        end_test("shift", err0);
    endtask

    task automatic test_zero();
        int err0;
        err0 = errors;
        exec_check(ALUOP_ADD, '0, '0, '0, rand_word(32), 1'b1, 0);
        read_back(4'd0);
        // start pulsed in the middle of a 31 bit shift
        exec_check(ALUOP_SLL, 4'd2, '0, 4'd15, 32'd31, 1'b1, 10);
        read_back(GLITCH_RD);
        read_back(4'd15);
        end_test("zero", err0);
    endtask

    initial begin
        I_clk = 1'b0;
        forever #(CLK_PERIOD / 2) I_clk = ~I_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        I_reset = 1'b1;
        start   = 1'b0;
        op      = ALUOP_ADD;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        imm     = '0;
        use_imm = 1'b0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        repeat (2) @(posedge I_clk);
        @(negedge I_clk);
        I_reset = 1'b0;
        test_reset();
        test_arith();
        test_compare();
        test_shift();
        test_zero();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_cpu_exec_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_exec_sva import alu_pkg::*; (
    input logic       I_clk,
    input logic       I_reset,
    input seq_state_t state,
    input logic       ready,
    input logic       done,
    input logic       alu_busy
);

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge I_clk) disable iff (I_reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    ready_after_reset: assert property (@(posedge I_clk)
        I_reset |=> ready)
        else $error("ready low right after reset");

    busy_after_reset: assert property (@(posedge I_clk)
        I_reset |=> !alu_busy)
        else $error("ALU busy right after reset");

    // a finished shift must not be restarted
    no_restart_after_shift: assert property (@(posedge I_clk) disable iff (I_reset)
        ((state == WAIT) && !alu_busy) |=> !alu_busy)
        else $error("ALU restarted a shift after busy dropped");

endmodule

`default_nettype wire

// ==== cpu_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_unit import alu_pkg::*; (
    input  logic      I_clk,
    input  logic      I_reset,
    input  logic      start,
    input  alu_op_t   op,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     imm,
    input  logic      use_imm,
    output logic      ready,
    output logic      done,
    output word_t     result,
    output logic      lt,
    output logic      ltu,
    output logic      eq
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     operand_imm;
    word_t     operand_b;
    logic      sel_imm;
    logic      alu_en;
    alu_op_t   alu_op;
    logic      alu_busy;
    logic      wr_en;
    reg_addr_t wr_addr;

    cpu_exec_seq seq (
        .I_clk       (I_clk),
        .I_reset     (I_reset),
        .start       (start),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .use_imm     (use_imm),
        .ready       (ready),
        .done        (done),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .operand_imm (operand_imm),
        .sel_imm     (sel_imm),
        .alu_en      (alu_en),
        .alu_op      (alu_op),
        .alu_busy    (alu_busy),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr)
    );

    cpu_regfile regfile (
        .I_clk    (I_clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (result)
    );

    // second operand is either a register or the latched immediate
    assign operand_b = sel_imm ? operand_imm : rs2_data;

    cpu_alu alu (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .en      (alu_en),
        .data_s1 (rs1_data),
        .data_s2 (operand_b),
        .op      (alu_op),
        .busy    (alu_busy),
        .data    (result),
        .lt      (lt),
        .ltu     (ltu),
        .eq      (eq)
    );

endmodule

`default_nettype wire

// ==== cpu_exec_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_seq import alu_pkg::*; (
    input  logic      I_clk,
    input  logic      I_reset,
    input  logic      start,
    input  alu_op_t   op,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     imm,
    input  logic      use_imm,
    output logic      ready,
    output logic      done,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output word_t     operand_imm,
    output logic      sel_imm,
    output logic      alu_en,
    output alu_op_t   alu_op,
    input  logic      alu_busy,
    output logic      wr_en,
    output reg_addr_t wr_addr
);

    seq_state_t state;
    seq_state_t state_next;
    logic       accept;
    logic       is_shift;

    assign accept = start && (state == IDLE);

    assign is_shift = (alu_op == ALUOP_SLL) || (alu_op == ALUOP_SRL) ||
                      (alu_op == ALUOP_SRA);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = EXEC;
                end
            end
            EXEC: begin
                // a shift only loads its operand here
                if (is_shift) begin
                    state_next = WAIT;
                end else begin
                    state_next = COMMIT;
                end
            end
            WAIT: begin
                if (!alu_busy) begin
                    state_next = COMMIT;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // operation fields held for the whole operation
    always_ff @(posedge I_clk) begin
        if (accept) begin
            alu_op      <= op;
            rs1_addr    <= rs1;
            rs2_addr    <= rs2;
            wr_addr     <= rd;
            operand_imm <= imm;
            sel_imm     <= use_imm;
        end
    end

    assign ready = (state == IDLE);

    // once busy drops the ALU must not see en again, or it restarts the shift
    assign alu_en = (state == EXEC) || ((state == WAIT) && alu_busy);

    // result and flags are already registered in the ALU during COMMIT
    assign done  = (state == COMMIT);
    assign wr_en = (state == COMMIT);

endmodule

`default_nettype wire

// ==== cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import alu_pkg::*; (
    input  logic    I_clk,
    input  logic    I_reset,
    input  logic    en,
    input  word_t   data_s1,
    input  word_t   data_s2,
    input  alu_op_t op,
    output logic    busy,
    output word_t   data,
    output logic    lt,
    output logic    ltu,
    output logic    eq
);

    word_t       sum;
    word_t       and_r;
    word_t       or_r;
    word_t       xor_r;
    logic [32:0] diff;
    logic        lt_c;
    logic        ltu_c;
    logic        eq_c;
    shamt_t      shiftcnt;

    always_comb begin
        sum   = data_s1 + data_s2;
        // extra top bit catches the borrow
        diff  = {1'b0, data_s1} - {1'b0, data_s2};
        and_r = data_s1 & data_s2;
        or_r  = data_s1 | data_s2;
        xor_r = data_s1 ^ data_s2;
    end

    always_comb begin
        ltu_c = diff[32];
        // differing signs flip the meaning of the borrow
        lt_c  = diff[32] ^ xor_r[31];
        eq_c  = (diff[31:0] == 32'd0);
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy     <= 1'b0;
            shiftcnt <= '0;
        end else if (en) begin
            case (op)
                ALUOP_SUB: data <= diff[31:0];
                ALUOP_AND: data <= and_r;
                ALUOP_OR:  data <= or_r;
                ALUOP_XOR: data <= xor_r;
                ALUOP_SLT: data <= {31'd0, lt_c};
                ALUOP_SLTU: data <= {31'd0, ltu_c};

                // bit-serial shifter, one position per enabled cycle
                ALUOP_SLL, ALUOP_SRL, ALUOP_SRA: begin
                    if (!busy) begin
                        busy     <= 1'b1;
                        data     <= data_s1;
                        shiftcnt <= shamt_t'(data_s2[4:0]);
                    end else if (shiftcnt != shamt_t'(0)) begin
                        case (op)
                            ALUOP_SLL: data <= {data[30:0], 1'b0};
                            ALUOP_SRL: data <= {1'b0, data[31:1]};
                            default:   data <= {data[31], data[31:1]};
                        endcase
                        shiftcnt <= shiftcnt - shamt_t'(1);
                    end else begin
                        busy <= 1'b0;
                    end
                end

                default: data <= sum;
            endcase

            lt  <= lt_c;
            ltu <= ltu_c;
            eq  <= eq_c;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import alu_pkg::*; (
    input  logic      I_clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [NUM_REGS];

    // entry 0 is never written, the read mux supplies the zero
    always_ff @(posedge I_clk) begin
        if (wr_en && (wr_addr != reg_addr_t'(0))) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        if (rs1_addr == reg_addr_t'(0)) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == reg_addr_t'(0)) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // one data word, operand or result
    typedef logic [31:0] word_t;

    // index into the register file
    typedef logic [3:0] reg_addr_t;

    // shift count, low bits of the second operand
    typedef logic [4:0] shamt_t;

    typedef logic [3:0] alu_op_t;

    // opcode values, anything above SRA executes as ADD
    localparam alu_op_t ALUOP_ADD  = 4'd0;
    localparam alu_op_t ALUOP_SUB  = 4'd1;
    localparam alu_op_t ALUOP_AND  = 4'd2;
    localparam alu_op_t ALUOP_OR   = 4'd3;
    localparam alu_op_t ALUOP_XOR  = 4'd4;
    localparam alu_op_t ALUOP_SLT  = 4'd5;
    localparam alu_op_t ALUOP_SLTU = 4'd6;
    localparam alu_op_t ALUOP_SLL  = 4'd7;
    localparam alu_op_t ALUOP_SRL  = 4'd8;
    localparam alu_op_t ALUOP_SRA  = 4'd9;

    localparam int NUM_REGS = 16;

    // execute sequencer states
    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        WAIT,
        COMMIT
    } seq_state_t;

endpackage

`default_nettype wire
